/* regBank_macros.svh */
// Register bank widths
`ifndef REGBANK_MACROS_SVH
`define REGBANK_MACROS_SVH

// Datapath

`define REGBANK_XLEN		64		// Register width
`define REGBANK_IMM_WIDTH	33		// Decoded immediate, top bit is sign

// SR layout

`define REGBANK_RB_BIT		29		// Register-bank select bit

// General file

`define REGBANK_GPR_COUNT	32		// R15 doubles as SP

`endif

/* regBankPkg.sv */
// Register bank types and ids
`include "regBank_macros.svh"

package regBankPkg;

	typedef logic [`REGBANK_XLEN-1:0] word_t;	// One register value
	typedef logic [6:0] regId_t;				// Register id from decode

	typedef enum regId_t
	{
		REG_R0 = 7'd0, REG_R1, REG_R2, REG_R3,
		REG_R4, REG_R5, REG_R6, REG_R7,
		REG_R8, REG_R9, REG_R10, REG_R11,
		REG_R12, REG_R13, REG_R14, REG_R15,
		REG_R16, REG_R17, REG_R18, REG_R19,
		REG_R20, REG_R21, REG_R22, REG_R23,
		REG_R24, REG_R25, REG_R26, REG_R27,
		REG_R28, REG_R29, REG_R30, REG_R31,

		REG_PC = 7'd32,		// Live bank
		REG_LR = 7'd33,
		REG_SR = 7'd34,
		REG_VBR = 7'd35,
		REG_GBR = 7'd38,
		REG_TBR = 7'd39,

		REG_SPC = 7'd40,	// Shadow bank
		REG_SLR = 7'd41,
		REG_SSR = 7'd42,
		REG_SSP = 7'd43,
		REG_SGB = 7'd46,
		REG_STB = 7'd47,

		REG_MMCR = 7'd48,
		REG_KRR = 7'd49,

		REG_IMM = 7'd126,	// Decoded immediate
		REG_ZZR = 7'd127	// Constant zero
	} regIdCode_e;

	// True for R0..R31
	function automatic logic isGpr(input regId_t id);
		return id < `REGBANK_GPR_COUNT;
	endfunction

endpackage

/* gprFile.sv */
// General register file
`timescale 1ns/100ps
`include "regBank_macros.svh"

module gprFile
(
	input	logic					clock,
	input	logic					reset,
	input	logic					regExHold,

	input	regBankPkg::regId_t		regIdRo,
	input	regBankPkg::word_t		regValRo,

	input	regBankPkg::regId_t		readIdA,
	input	regBankPkg::regId_t		readIdB,
	input	regBankPkg::regId_t		readIdC,
	output	regBankPkg::word_t		readValA,
	output	regBankPkg::word_t		readValB,
	output	regBankPkg::word_t		readValC,

	input	logic					bankSwap,
	input	regBankPkg::word_t		shadowSp,
	output	regBankPkg::word_t		gprSp
);

	import regBankPkg::*;

	localparam int gprIdxW = $clog2(`REGBANK_GPR_COUNT);
	localparam logic [gprIdxW-1:0] spIdx = gprIdxW'(REG_R15);	// Stack pointer slot

	word_t		gprRegs [`REGBANK_GPR_COUNT];
	logic		roCommit;

	// Ro only lands on a general id and only when execute is not stalled
	assign roCommit = !regExHold && isGpr(regIdRo);

	// Storage read with same-cycle bypass of the Ro write
	function automatic word_t readPort(input regId_t readId);
		if (roCommit && (readId == regIdRo))
			return regValRo;
		return gprRegs[readId[gprIdxW-1:0]];
	endfunction

	always_comb
	begin
		readValA = readPort(readIdA);
		readValB = readPort(readIdB);
		readValC = readPort(readIdC);
	end

	assign gprSp = gprRegs[spIdx];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REGBANK_GPR_COUNT; i++)
				gprRegs[i] <= '0;
		end
		else
		begin
			if (roCommit)
				gprRegs[regIdRo[gprIdxW-1:0]] <= regValRo;

			// Bank change brings in the other SP, overriding any Ro write to R15
			if (bankSwap)
				gprRegs[spIdx] <= shadowSp;
		end
	end

endmodule

/* operandSelect.sv */
// Operand source select
`timescale 1ns/100ps
`include "regBank_macros.svh"

module operandSelect
#(
	parameter bit allowPc = 1'b1				// Off for ports that never see PC
)
(
	input	regBankPkg::regId_t			readId,
	input	regBankPkg::word_t			gprVal,
	input	regBankPkg::word_t			idNextPc,
	input	logic [`REGBANK_IMM_WIDTH-1:0]	idImm,
	output	regBankPkg::word_t			operandVal
);

	import regBankPkg::*;

	localparam int extW = `REGBANK_XLEN - `REGBANK_IMM_WIDTH;

	word_t		immExt;

	assign immExt = {{extW{idImm[`REGBANK_IMM_WIDTH-1]}}, idImm};	// Sign extend

	always_comb
	begin
		if (isGpr(readId))
			operandVal = gprVal;
		else
		begin
			case (readId)
				REG_PC:		operandVal = allowPc ? idNextPc : '0;
				REG_IMM:	operandVal = immExt;
				REG_ZZR:	operandVal = '0;
				default:	operandVal = '0;	// Undefined id reads zero
			endcase
		end
	end

endmodule

/* ctrlRegFile.sv */
// Control register file
`timescale 1ns/100ps
`include "regBank_macros.svh"

module ctrlRegFile
(
	input	logic					clock,
	input	logic					reset,
	input	logic					regExHold,

	input	regBankPkg::regId_t		regIdCo,
	input	regBankPkg::word_t		regValCo,
	input	regBankPkg::regId_t		regIdCm,
	output	regBankPkg::word_t		regValCm,

	input	regBankPkg::word_t		idNextPc,
	input	regBankPkg::word_t		gprSp,
	output	logic					bankSwap,
	output	regBankPkg::word_t		shadowSp,

	output	regBankPkg::word_t		oregPc,
	output	regBankPkg::word_t		oregLr,
	output	regBankPkg::word_t		oregSr,
	output	regBankPkg::word_t		oregVbr,
	output	regBankPkg::word_t		oregGbr,
	output	regBankPkg::word_t		oregTbr,
	output	regBankPkg::word_t		oregMmcr,
	output	regBankPkg::word_t		oregKrr
);

	import regBankPkg::*;

	word_t		regPc, regLr, regSr, regVbr, regGbr, regTbr;	// Live bank
	word_t		regSpc, regSlr, regSsr, regSsp, regSgb, regStb;	// Shadow bank
	word_t		regMmcr, regKrr;

	logic		coKnown;
	logic		coCommit;

	always_comb
	begin
		case (regIdCo)
			REG_PC, REG_LR, REG_SR, REG_VBR, REG_GBR, REG_TBR,
			REG_SPC, REG_SLR, REG_SSR, REG_SSP, REG_SGB, REG_STB,
			REG_MMCR, REG_KRR:
				coKnown = 1'b1;
			default:
				coKnown = 1'b0;
		endcase
	end

	assign coCommit = !regExHold && coKnown;

	// Flipping SR.RB selects the other bank
	assign bankSwap = !regExHold && (regIdCo == REG_SR) &&
		(regValCo[`REGBANK_RB_BIT] != regSr[`REGBANK_RB_BIT]);

	always_comb
	begin
		case (regIdCm)
			REG_PC:		regValCm = idNextPc;	// PC as seen by this instruction
			REG_LR:		regValCm = regLr;
			REG_SR:		regValCm = regSr;
			REG_VBR:	regValCm = regVbr;
			REG_GBR:	regValCm = regGbr;
			REG_TBR:	regValCm = regTbr;
			REG_SPC:	regValCm = regSpc;
			REG_SLR:	regValCm = regSlr;
			REG_SSR:	regValCm = regSsr;
			REG_SSP:	regValCm = regSsp;
			REG_SGB:	regValCm = regSgb;
			REG_STB:	regValCm = regStb;
			REG_MMCR:	regValCm = regMmcr;
			REG_KRR:	regValCm = regKrr;
			default:	regValCm = '0;
		endcase

		if (coCommit && (regIdCm == regIdCo))
			regValCm = regValCo;			// Bypass the Co write
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			regPc <= '0;
			regLr <= '0;
			regSr <= '0;
			regVbr <= '0;
			regGbr <= '0;
			regTbr <= '0;
			regSpc <= '0;
			regSlr <= '0;
			regSsr <= '0;
			regSsp <= '0;
			regSgb <= '0;
			regStb <= '0;
			regMmcr <= '0;
			regKrr <= '0;
		end
		else if (bankSwap)
		begin
			regSr <= regValCo;
			regSsr <= regSr;				// Old SR kept for return
			regPc <= regSpc;
			regSpc <= regPc;
			regLr <= regSlr;
			regSlr <= regLr;
			regGbr <= regSgb;
			regSgb <= regGbr;
			regTbr <= regStb;
			regStb <= regTbr;
			regSsp <= gprSp;				// R15 side handled in gprFile
		end
		else if (!regExHold)
		begin
			regPc <= (coCommit && (regIdCo == REG_PC)) ? regValCo : idNextPc;

			if (coCommit)
			begin
				case (regIdCo)
					REG_LR:		regLr <= regValCo;
					REG_SR:		regSr <= regValCo;	// Same RB bit, no swap
					REG_VBR:	regVbr <= regValCo;
					REG_GBR:	regGbr <= regValCo;
					REG_TBR:	regTbr <= regValCo;
					REG_SPC:	regSpc <= regValCo;
					REG_SLR:	regSlr <= regValCo;
					REG_SSR:	regSsr <= regValCo;
					REG_SSP:	regSsp <= regValCo;
					REG_SGB:	regSgb <= regValCo;
					REG_STB:	regStb <= regValCo;
					REG_MMCR:	regMmcr <= regValCo;
					REG_KRR:	regKrr <= regValCo;
					default:	;
				endcase
			end
		end
	end

	assign shadowSp = regSsp;

	assign oregPc = regPc;
	assign oregLr = regLr;
	assign oregSr = regSr;
	assign oregVbr = regVbr;
	assign oregGbr = regGbr;
	assign oregTbr = regTbr;
	assign oregMmcr = regMmcr;
	assign oregKrr = regKrr;

endmodule

/* regBank.sv */
// CPU register bank
`timescale 1ns/100ps
`include "regBank_macros.svh"

module regBank
(
	input	logic					clock,
	input	logic					reset,
	input	logic					regExHold,

	input	regBankPkg::regId_t		regIdRm,
	input	regBankPkg::regId_t		regIdRn,
	input	regBankPkg::regId_t		regIdRi,
	input	regBankPkg::regId_t		regIdRo,
	input	regBankPkg::regId_t		regIdCm,
	input	regBankPkg::regId_t		regIdCo,

	input	regBankPkg::word_t		regValRo,
	input	regBankPkg::word_t		regValCo,
	input	regBankPkg::word_t		idNextPc,
	input	logic [`REGBANK_IMM_WIDTH-1:0]	idImm,

	output	regBankPkg::word_t		regValRm,
	output	regBankPkg::word_t		regValRn,
	output	regBankPkg::word_t		regValRi,
	output	regBankPkg::word_t		regValCm,

	output	regBankPkg::word_t		oregPc,
	output	regBankPkg::word_t		oregLr,
	output	regBankPkg::word_t		oregSr,
	output	regBankPkg::word_t		oregVbr,
	output	regBankPkg::word_t		oregGbr,
	output	regBankPkg::word_t		oregTbr,
	output	regBankPkg::word_t		oregSp,
	output	regBankPkg::word_t		oregMmcr,
	output	regBankPkg::word_t		oregKrr
);

	import regBankPkg::*;

	word_t		gprValRm, gprValRn, gprValRi;
	word_t		shadowSp;
	logic		bankSwap;

	gprFile gprFile_i
	(
		.clock(clock),			.reset(reset),			.regExHold(regExHold),
		.regIdRo(regIdRo),		.regValRo(regValRo),
		.readIdA(regIdRm),		.readValA(gprValRm),
		.readIdB(regIdRn),		.readValB(gprValRn),
		.readIdC(regIdRi),		.readValC(gprValRi),
		.bankSwap(bankSwap),	.shadowSp(shadowSp),	.gprSp(oregSp)
	);

	operandSelect #(.allowPc(1'b1)) rmSel
	(
		.readId(regIdRm), .gprVal(gprValRm), .idNextPc(idNextPc), .idImm(idImm),
		.operandVal(regValRm)
	);

	operandSelect #(.allowPc(1'b1)) rnSel
	(
		.readId(regIdRn), .gprVal(gprValRn), .idNextPc(idNextPc), .idImm(idImm),
		.operandVal(regValRn)
	);

	operandSelect #(.allowPc(1'b0)) riSel		// Index port, no PC
	(
		.readId(regIdRi), .gprVal(gprValRi), .idNextPc(idNextPc), .idImm(idImm),
		.operandVal(regValRi)
	);

	ctrlRegFile ctrlRegFile_i
	(
		.clock(clock),			.reset(reset),			.regExHold(regExHold),
		.regIdCo(regIdCo),		.regValCo(regValCo),
		.regIdCm(regIdCm),		.regValCm(regValCm),
		.idNextPc(idNextPc),	.gprSp(oregSp),
		.bankSwap(bankSwap),	.shadowSp(shadowSp),
		.oregPc(oregPc),		.oregLr(oregLr),		.oregSr(oregSr),
		.oregVbr(oregVbr),		.oregGbr(oregGbr),		.oregTbr(oregTbr),
		.oregMmcr(oregMmcr),	.oregKrr(oregKrr)
	);

endmodule

/* regBank_chk.sv */
// Register bank assertions
`timescale 1ns/100ps

module regBank_chk
(
	input	logic			clock,
	input	logic			reset,
	input	logic			regExHold,
	input	logic			bankSwap,
	input	logic [63:0]	regValCo,
	input	logic [63:0]	oregPc,
	input	logic [63:0]	oregLr,
	input	logic [63:0]	oregSr,
	input	logic [63:0]	oregVbr,
	input	logic [63:0]	oregGbr,
	input	logic [63:0]	oregTbr,
	input	logic [63:0]	oregSp,
	input	logic [63:0]	oregMmcr,
	input	logic [63:0]	oregKrr
);

	resetClears: assert property (@(posedge clock) reset |=>
		(oregPc == '0 && oregLr == '0 && oregSr == '0 && oregVbr == '0 && oregGbr == '0 &&
		oregTbr == '0 && oregSp == '0 && oregMmcr == '0 && oregKrr == '0))
		else $error("Control outputs not zero after reset");

	holdKeepsPc: assert property (@(posedge clock) (regExHold && !reset) |=> $stable(oregPc))
		else $error("PC changed during a held cycle");

	swapLoadsSr: assert property (@(posedge clock)
		(bankSwap && !reset) |=> oregSr == $past(regValCo))
		else $error("SR does not hold the written value after a bank swap");

endmodule

bind regBank regBank_chk chk_i
(
	.clock(clock), .reset(reset), .regExHold(regExHold), .bankSwap(bankSwap),
	.regValCo(regValCo), .oregPc(oregPc), .oregLr(oregLr), .oregSr(oregSr),
	.oregVbr(oregVbr), .oregGbr(oregGbr), .oregTbr(oregTbr), .oregSp(oregSp),
	.oregMmcr(oregMmcr), .oregKrr(oregKrr)
);

/* regBankTb.sv */
// Register bank testbench
`timescale 1ns/100ps
`include "regBank_macros.svh"

module regBankTb;

	import regBankPkg::*;

	localparam int clockPeriod = 40;
	localparam int testCycles = 160;		// Sum of all test task lengths
	localparam int marginCycles = 100;

	logic		clock;
	logic		reset;
	logic		regExHold;
	regId_t		regIdRm, regIdRn, regIdRi, regIdRo, regIdCm, regIdCo;
	word_t		regValRo, regValCo, idNextPc;
	logic [`REGBANK_IMM_WIDTH-1:0]	idImm;
	word_t		regValRm, regValRn, regValRi, regValCm;
	word_t		oregPc, oregLr, oregSr, oregVbr, oregGbr, oregTbr, oregSp;
	word_t		oregMmcr, oregKrr;

	word_t		gprModel [`REGBANK_GPR_COUNT];
	word_t		ctrlModel [128];			// Indexed by control id
	int			errors = 0;
	logic [31:0]	lfsrState = 32'h8330_bcba;

	regBank dut_i
	(
		.clock(clock), .reset(reset), .regExHold(regExHold),
		.regIdRm(regIdRm), .regIdRn(regIdRn), .regIdRi(regIdRi),
		.regIdRo(regIdRo), .regIdCm(regIdCm), .regIdCo(regIdCo),
		.regValRo(regValRo), .regValCo(regValCo), .idNextPc(idNextPc), .idImm(idImm),
		.regValRm(regValRm), .regValRn(regValRn), .regValRi(regValRi), .regValCm(regValCm),
		.oregPc(oregPc), .oregLr(oregLr), .oregSr(oregSr), .oregVbr(oregVbr),
		.oregGbr(oregGbr), .oregTbr(oregTbr), .oregSp(oregSp),
		.oregMmcr(oregMmcr), .oregKrr(oregKrr)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod/2) clock = ~clock;
	end

	// Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
	function logic nextBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'hA300_0000;
		return outBit;
	endfunction

	function word_t randWord(input int bits);
		word_t v;
		v = '0;
		for (int i = 0; i < bits; i++)
			v = {v[62:0], nextBit()};
		return v;
	endfunction

	// Two's complement value of a decoded immediate
	function word_t immValue(input logic [`REGBANK_IMM_WIDTH-1:0] imm);
		word_t v;
		v = word_t'(imm);
		if (imm[`REGBANK_IMM_WIDTH-1])
			v = v - (word_t'(1) << `REGBANK_IMM_WIDTH);	// Negative immediate
		return v;
	endfunction

	// Live control output for an id
	function word_t ctrlOut(input regId_t id);
		case (id)
			REG_PC:		return oregPc;
			REG_LR:		return oregLr;
			REG_SR:		return oregSr;
			REG_VBR:	return oregVbr;
			REG_GBR:	return oregGbr;
			REG_TBR:	return oregTbr;
			REG_MMCR:	return oregMmcr;
			REG_KRR:	return oregKrr;
			default:	return '0;
		endcase
	endfunction

	// Exchange a live and a shadow entry of the model
	function void swapModelRegs(input regId_t liveId, input regId_t shadowId);
		word_t tmp;
		tmp = ctrlModel[liveId];
		ctrlModel[liveId] = ctrlModel[shadowId];
		ctrlModel[shadowId] = tmp;
	endfunction

	task checkVal(input string testName, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task setIdle();
		regExHold <= 1'b0;
		regIdRo <= REG_ZZR;
		regIdCo <= REG_ZZR;
	endtask

	task testResetState();
		regId_t	ctrlIds [8];
		ctrlIds = '{REG_PC, REG_LR, REG_SR, REG_VBR, REG_GBR, REG_TBR, REG_MMCR, REG_KRR};
		@(negedge clock);
		checkVal("reset sp", '0, oregSp);
		foreach (ctrlIds[i])
			checkVal("reset ctrl", '0, ctrlOut(ctrlIds[i]));
		for (int i = 0; i < 32; i++)
		begin
			@(posedge clock);
			regIdRm <= regId_t'(i);
			regIdRn <= regId_t'(i);
			regIdRi <= regId_t'(i);
			@(negedge clock);
			checkVal("reset rm", '0, regValRm);
			checkVal("reset rn", '0, regValRn);
			checkVal("reset ri", '0, regValRi);
		end
	endtask

	task testGeneralWrites();
		word_t val;
		for (int i = 0; i < 32; i++)
		begin
			val = randWord(64);
			@(posedge clock);
			regIdRo <= regId_t'(i);
			regValRo <= val;
			regIdRm <= regId_t'(i);
			regIdRn <= regId_t'(i);
			regIdRi <= regId_t'(i);
			gprModel[i] = val;
			@(negedge clock);
			checkVal("forward rm", val, regValRm);	// Same-cycle bypass
			checkVal("forward rn", val, regValRn);
			checkVal("forward ri", val, regValRi);
		end
		@(posedge clock);
		regIdRo <= REG_LR;							// Not general, dropped
		regValRo <= randWord(64);
		for (int i = 0; i < 32; i++)
		begin
			@(posedge clock);
			setIdle();
			regIdRm <= regId_t'(i);
			regIdRn <= regId_t'((i + 1) % 32);
			regIdRi <= regId_t'((i + 2) % 32);
			@(negedge clock);
			checkVal("readback rm", gprModel[i], regValRm);
			checkVal("readback rn", gprModel[(i + 1) % 32], regValRn);
			checkVal("readback ri", gprModel[(i + 2) % 32], regValRi);
		end
		checkVal("ro to lr", ctrlModel[REG_LR], oregLr);
	endtask

	task testOperandSources();
		logic [`REGBANK_IMM_WIDTH-1:0]	imms [3];
		word_t	np, immVal;
		imms = '{33'h0_7ABC_1234, 33'h1_0000_0005, 33'(randWord(33))};
		foreach (imms[i])
		begin
			immVal = immValue(imms[i]);
			@(posedge clock);
			idImm <= imms[i];
			regIdRm <= REG_IMM;
			regIdRn <= REG_IMM;
			regIdRi <= REG_IMM;
			@(negedge clock);
			checkVal("imm rm", immVal, regValRm);
			checkVal("imm rn", immVal, regValRn);
			checkVal("imm ri", immVal, regValRi);
		end
		@(posedge clock);
		regIdRm <= REG_ZZR;
		regIdRn <= regId_t'(7'd100);				// Undefined id
		@(negedge clock);
		checkVal("zzr", '0, regValRm);
		checkVal("undefined", '0, regValRn);
		np = randWord(64);
		@(posedge clock);
		idNextPc <= np;
		regIdRm <= REG_PC;
		regIdRn <= REG_PC;
		regIdRi <= REG_PC;
		@(negedge clock);
		checkVal("pc rm", np, regValRm);
		checkVal("pc rn", np, regValRn);
		checkVal("pc ri", '0, regValRi);
	endtask

	task testHold();
		word_t pcA, pcB, roVal, coVal;
		pcA = randWord(64);
		pcB = randWord(64);
		roVal = randWord(64);
		coVal = randWord(64);
		@(posedge clock);
		setIdle();
		idNextPc <= pcA;
		@(posedge clock);
		regExHold <= 1'b1;
		regIdRo <= REG_R3;
		regValRo <= roVal;
		regIdCo <= REG_LR;
		regValCo <= coVal;
		idNextPc <= pcB;
		regIdRm <= REG_R3;
		regIdCm <= REG_LR;
		@(negedge clock);
		checkVal("hold pc", pcA, oregPc);
		checkVal("hold no fwd ro", gprModel[3], regValRm);
		checkVal("hold no fwd co", ctrlModel[REG_LR], regValCm);
		@(posedge clock);							// Held edge
		@(negedge clock);
		checkVal("held pc", pcA, oregPc);
		checkVal("held lr", ctrlModel[REG_LR], oregLr);
		checkVal("held r3", gprModel[3], regValRm);
		@(posedge clock);
		regExHold <= 1'b0;
		@(negedge clock);
		checkVal("release fwd", roVal, regValRm);
		@(posedge clock);
		setIdle();
		gprModel[3] = roVal;
		ctrlModel[REG_LR] = coVal;
		@(negedge clock);
		checkVal("release lr", coVal, oregLr);
		checkVal("release pc", pcB, oregPc);
		checkVal("release r3", roVal, regValRm);
	endtask

	task testControlRegs();
		regId_t	ids [6];
		word_t	val, np;
		ids = '{REG_LR, REG_VBR, REG_GBR, REG_TBR, REG_MMCR, REG_KRR};
		foreach (ids[i])
		begin
			val = randWord(64);
			np = randWord(64);
			@(posedge clock);
			regIdCo <= ids[i];
			regValCo <= val;
			regIdCm <= ids[i];
			idNextPc <= np;
			@(negedge clock);
			checkVal("cm forward", val, regValCm);
			@(posedge clock);
			setIdle();
			ctrlModel[ids[i]] = val;
			@(negedge clock);
			checkVal("ctrl out", val, ctrlOut(ids[i]));
			checkVal("ctrl cm", val, regValCm);
			checkVal("pc follows", np, oregPc);
		end
		val = randWord(64);
		np = randWord(64);
		@(posedge clock);
		regIdCo <= REG_PC;
		regValCo <= val;
		regIdCm <= REG_PC;
		idNextPc <= np;
		@(negedge clock);
		checkVal("pc cm forward", val, regValCm);
		@(posedge clock);
		setIdle();
		@(negedge clock);
		checkVal("pc written", val, oregPc);
		@(negedge clock);
		checkVal("pc resumes", np, oregPc);
	endtask

	task testBankSwap();
		regId_t	shadowIds [5];
		regId_t	cmIds [6];
		word_t	np, oldSr, newSr, oldR15, tmp;
		shadowIds = '{REG_SPC, REG_SLR, REG_SGB, REG_STB, REG_SSP};
		cmIds = '{REG_SPC, REG_SLR, REG_SGB, REG_STB, REG_SSR, REG_SSP};
		np = randWord(64);
		oldR15 = randWord(64);
		@(posedge clock);
		idNextPc <= np;
		regIdRo <= REG_R15;
		regValRo <= oldR15;
		gprModel[15] = oldR15;
		foreach (shadowIds[i])
		begin
			tmp = randWord(64);
			regIdCo <= shadowIds[i];
			regValCo <= tmp;
			ctrlModel[shadowIds[i]] = tmp;
			@(posedge clock);
			regIdRo <= REG_ZZR;
		end
		oldSr = randWord(64);
		oldSr[`REGBANK_RB_BIT] = ctrlModel[REG_SR][`REGBANK_RB_BIT];	// Keep the current bank
		regIdCo <= REG_SR;
		regValCo <= oldSr;
		ctrlModel[REG_SR] = oldSr;
		@(posedge clock);
		ctrlModel[REG_PC] = np;
		newSr = randWord(64);
		newSr[`REGBANK_RB_BIT] = ~oldSr[`REGBANK_RB_BIT];
		regIdCo <= REG_SR;
		regValCo <= newSr;
		regIdRo <= REG_R15;						// Lost to the swap
		regValRo <= randWord(64);
		@(posedge clock);
		setIdle();
		ctrlModel[REG_SR] = newSr;
		ctrlModel[REG_SSR] = oldSr;
		swapModelRegs(REG_PC, REG_SPC);
		swapModelRegs(REG_LR, REG_SLR);
		swapModelRegs(REG_GBR, REG_SGB);
		swapModelRegs(REG_TBR, REG_STB);
		gprModel[15] = ctrlModel[REG_SSP];
		ctrlModel[REG_SSP] = oldR15;
		@(negedge clock);
		checkVal("swap sr", newSr, oregSr);
		checkVal("swap pc", ctrlModel[REG_PC], oregPc);
		checkVal("swap lr", ctrlModel[REG_LR], oregLr);
		checkVal("swap gbr", ctrlModel[REG_GBR], oregGbr);
		checkVal("swap tbr", ctrlModel[REG_TBR], oregTbr);
		checkVal("swap sp", gprModel[15], oregSp);
		foreach (cmIds[i])
		begin
			@(posedge clock);
			regIdCm <= cmIds[i];
			@(negedge clock);
			checkVal("swap shadow", ctrlModel[cmIds[i]], regValCm);
		end
		newSr = randWord(64);
		newSr[`REGBANK_RB_BIT] = ctrlModel[REG_SR][`REGBANK_RB_BIT];	// No bank change
		@(posedge clock);
		regIdCo <= REG_SR;
		regValCo <= newSr;
		regIdCm <= REG_SSR;
		@(posedge clock);
		setIdle();
		ctrlModel[REG_SR] = newSr;
		@(negedge clock);
		checkVal("no swap sr", newSr, oregSr);
		checkVal("no swap lr", ctrlModel[REG_LR], oregLr);
		checkVal("no swap sp", gprModel[15], oregSp);
		checkVal("no swap ssr", ctrlModel[REG_SSR], regValCm);
	endtask

	initial
	begin
		#((testCycles + marginCycles) * clockPeriod);
		$display("Timeout: the tests did not finish in the expected time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		regExHold = 1'b0;
		regIdRm = REG_ZZR;
		regIdRn = REG_ZZR;
		regIdRi = REG_ZZR;
		regIdRo = REG_ZZR;
		regIdCm = REG_ZZR;
		regIdCo = REG_ZZR;
		regValRo = '0;
		regValCo = '0;
		idNextPc = '0;
		idImm = '0;
		foreach (gprModel[i])
			gprModel[i] = '0;
		foreach (ctrlModel[i])
			ctrlModel[i] = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		testResetState();
		testGeneralWrites();
		testOperandSources();
		testHold();
		testControlRegs();
		testBankSwap();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
regBankPkg.sv
gprFile.sv
operandSelect.sv
ctrlRegFile.sv
regBank.sv
regBank_chk.sv
regBankTb.sv

/* Bender.yml */
package:
  name: regBank

sources:
  - include_dirs:
      - .
    files:
      - regBankPkg.sv
      - gprFile.sv
      - operandSelect.sv
      - ctrlRegFile.sv
      - regBank.sv
  - target: test
    include_dirs:
      - .
    files:
      - regBank_chk.sv
      - regBankTb.sv
